// ==== Makefile ====
# Verilator build and run of the address-generation testbench

SIM_TOP   ?= agen_tb
VERILATOR ?= verilator
VFLAGS    ?= --assert --timescale 1ns/1ps
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: SIM_TOP VERILATOR VFLAGS FILELIST OBJ_DIR"

test:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(SIM_TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(SIM_TOP) 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/agen_assert.sv ====
module agen_assert (
   input logic         clk,
   input logic         rst,
   input logic         in_valid,
   input uop_pkg::op_t in_op,
   input logic         out_valid,
   input logic         out_limit_exc
);
   timeunit 1ns;
   timeprecision 1ps;

   valid_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

   // One-cycle latency from in_valid
   valid_follows_input: assert property (@(posedge clk) disable iff (rst)
      1'b1 |=> out_valid == $past(in_valid))
      else $error("out_valid does not follow in_valid by one cycle");

   exc_needs_valid: assert property (@(posedge clk) disable iff (rst)
      out_limit_exc |-> out_valid)
      else $error("out_limit_exc high while out_valid low");

   no_exc_on_intr: assert property (@(posedge clk) disable iff (rst)
      out_limit_exc |-> $past(in_op) != uop_pkg::op_intr)
      else $error("out_limit_exc raised for an interrupt vector fetch");

endmodule

bind agen_stage agen_assert u_agen_assert (
   .clk           (clk),
   .rst           (rst),
   .in_valid      (in_valid),
   .in_op         (in_op),
   .out_valid     (out_valid),
   .out_limit_exc (out_limit_exc)
);

// ==== dv/agen_tb.sv ====
module agen_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int stack_seg     = 2;
   localparam int num_segs      = 8;
   localparam int drain_timeout = 20;

   typedef struct packed {
      agen_pkg::addr_t    addr;
      agen_pkg::addr_t    offset;
      uop_pkg::mem_size_t size;
      agen_pkg::tag_t     tag;
      logic               exc;
   } expect_t;

   logic               clk;
   logic               rst;
   logic               cfg_we;
   agen_pkg::seg_id_t  cfg_seg;
   agen_pkg::addr_t    cfg_base;
   agen_pkg::addr_t    cfg_limit;
   logic               in_valid;
   uop_pkg::op_t       in_op;
   agen_pkg::seg_id_t  in_seg;
   uop_pkg::mem_size_t in_size;
   agen_pkg::addr_t    in_base;
   agen_pkg::addr_t    in_disp;
   agen_pkg::addr_t    in_esp;
   logic               in_df;
   logic               in_rep_steady;
   agen_pkg::addr_t    in_intr_addr;
   agen_pkg::tag_t     in_tag;
   logic               out_valid;
   agen_pkg::addr_t    out_addr;
   agen_pkg::addr_t    out_offset;
   uop_pkg::mem_size_t out_size;
   agen_pkg::tag_t     out_tag;
   logic               out_limit_exc;

   // Model copy of the segment table and the string pointers
   agen_pkg::addr_t   ref_base [num_segs];
   agen_pkg::addr_t   ref_limit [num_segs];
   agen_pkg::addr_t   ref_src_ptr;
   agen_pkg::addr_t   ref_dst_ptr;
   agen_pkg::seg_id_t ref_src_seg;
   agen_pkg::seg_id_t ref_dst_seg;

   expect_t        exp_q [$];
   logic [31:0]    rand_state;
   agen_pkg::tag_t tag_cnt;

   agen_top #(
      .STACK_SEG (stack_seg),
      .NUM_SEGS  (num_segs)
   ) agen_top_inst (
      .clk (clk), .rst (rst), .cfg_we (cfg_we), .cfg_seg (cfg_seg),
      .cfg_base (cfg_base), .cfg_limit (cfg_limit), .in_valid (in_valid),
      .in_op (in_op), .in_seg (in_seg), .in_size (in_size), .in_base (in_base),
      .in_disp (in_disp), .in_esp (in_esp), .in_df (in_df),
      .in_rep_steady (in_rep_steady), .in_intr_addr (in_intr_addr), .in_tag (in_tag),
      .out_valid (out_valid), .out_addr (out_addr), .out_offset (out_offset),
      .out_size (out_size), .out_tag (out_tag), .out_limit_exc (out_limit_exc)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic agen_pkg::addr_t size_bytes(input uop_pkg::mem_size_t size);
      case (size)
         uop_pkg::size_1: return 32'd1;
         uop_pkg::size_2: return 32'd2;
         default:         return 32'd4;
      endcase
   endfunction

   // Expected result of one micro-op, advancing the model pointers
   function automatic expect_t predict(input uop_pkg::op_t op, input agen_pkg::seg_id_t seg,
         input uop_pkg::mem_size_t size, input agen_pkg::addr_t base,
         input agen_pkg::addr_t disp, input agen_pkg::addr_t esp, input logic df,
         input logic steady, input agen_pkg::addr_t intr, input agen_pkg::tag_t tag);
      expect_t           e;
      agen_pkg::addr_t   bytes;
      agen_pkg::addr_t   off;
      agen_pkg::seg_id_t sg;
      logic [32:0]       last;
      bytes = size_bytes(size);
      sg = seg;
      off = base + disp;
      if (op == uop_pkg::op_stack) begin
         sg = agen_pkg::seg_id_t'(stack_seg);
         off = esp;
      end else if (op == uop_pkg::op_intr) begin
         off = intr;
      end else if (op == uop_pkg::op_cmps_src || op == uop_pkg::op_cmps_dst) begin
         off = base;
         if (steady) begin
            off = (op == uop_pkg::op_cmps_src) ? ref_src_ptr : ref_dst_ptr;
            sg = (op == uop_pkg::op_cmps_src) ? ref_src_seg : ref_dst_seg;
         end
         off = df ? off - bytes : off + bytes;
         if (op == uop_pkg::op_cmps_src) begin
            ref_src_ptr = off;
            ref_src_seg = sg;
         end else begin
            ref_dst_ptr = off;
            ref_dst_seg = sg;
         end
      end
      last = {1'b0, off} + {1'b0, bytes} - 33'd1;
      e.offset = off;
      e.addr = (op == uop_pkg::op_intr) ? off : ref_base[sg] + off;
      e.exc = (op != uop_pkg::op_intr) && (last > {1'b0, ref_limit[sg]});
      e.size = size;
      e.tag = tag;
      return e;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_addr(input string what, input agen_pkg::addr_t got,
         input agen_pkg::addr_t exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_tag(input agen_pkg::tag_t got, input agen_pkg::tag_t exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %0d ns: out_tag got %h, expected %h", $time, got, exp));
   endtask

   task automatic check_size(input uop_pkg::mem_size_t got, input uop_pkg::mem_size_t exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %0d ns: out_size got %0d, expected %0d", $time, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input agen_pkg::tag_t tag);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %0d ns: out_limit_exc got %b, expected %b (tag %h)",
                            $time, got, exp, tag));
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      cfg_we   <= 1'b0;
      in_valid <= 1'b0;
   endtask

   task automatic write_seg(input agen_pkg::seg_id_t seg, input agen_pkg::addr_t base,
         input agen_pkg::addr_t limit);
      @(posedge clk);
      in_valid  <= 1'b0;
      cfg_we    <= 1'b1;
      cfg_seg   <= seg;
      cfg_base  <= base;
      cfg_limit <= limit;
      ref_base[seg]  = base;
      ref_limit[seg] = limit;
   endtask

   task automatic issue_uop(input uop_pkg::op_t op, input agen_pkg::seg_id_t seg,
         input uop_pkg::mem_size_t size, input agen_pkg::addr_t base,
         input agen_pkg::addr_t disp, input agen_pkg::addr_t esp, input logic df,
         input logic steady, input agen_pkg::addr_t intr);
      @(posedge clk);
      cfg_we        <= 1'b0;
      in_valid      <= 1'b1;
      in_op         <= op;
      in_seg        <= seg;
      in_size       <= size;
      in_base       <= base;
      in_disp       <= disp;
      in_esp        <= esp;
      in_df         <= df;
      in_rep_steady <= steady;
      in_intr_addr  <= intr;
      in_tag        <= tag_cnt;
      exp_q.push_back(predict(op, seg, size, base, disp, esp, df, steady, intr, tag_cnt));
      tag_cnt = tag_cnt + agen_pkg::tag_t'(1);
   endtask

   task automatic random_uop();
      logic [31:0]  r;
      uop_pkg::op_t op;
      r = next_rand();
      op = (r[1:0] == 2'd0) ? uop_pkg::op_intr :
           (r[1:0] == 2'd1) ? uop_pkg::op_stack : uop_pkg::op_mem;
      issue_uop(op, r[6:4], r[9:8], next_rand() & 32'h0001_ffff, next_rand() & 32'h0fff,
                next_rand() & 32'h0001_ffff, r[12], r[13], next_rand());
   endtask

   // Last byte on the limit, then one byte past it, for each size code
   task automatic limit_boundary(input uop_pkg::op_t op, input agen_pkg::seg_id_t seg);
      agen_pkg::seg_id_t  sg;
      agen_pkg::addr_t    off;
      uop_pkg::mem_size_t size;
      sg = (op == uop_pkg::op_stack) ? agen_pkg::seg_id_t'(stack_seg) : seg;
      for (int s = 0; s < 4; s++) begin
         size = uop_pkg::mem_size_t'(s);
         off = ref_limit[sg] - size_bytes(size) + 32'd1;
         issue_uop(op, seg, size, off, 32'd0, off, 1'b0, 1'b0, off);
         issue_uop(op, seg, size, off + 32'd1, 32'd0, off + 32'd1, 1'b0, 1'b0,
                   off + 32'd1);
      end
   endtask

   task automatic string_sequence(input int pairs);
      logic [31:0]        r;
      uop_pkg::mem_size_t size;
      r = next_rand();
      size = uop_pkg::mem_size_t'(r % 3);
      issue_uop(uop_pkg::op_cmps_src, r[6:4], size, next_rand() & 32'hffff, next_rand(),
                32'd0, r[12], 1'b0, 32'd0);
      issue_uop(uop_pkg::op_cmps_dst, r[10:8], size, next_rand() & 32'hffff, next_rand(),
                32'd0, r[12], 1'b0, 32'd0);
      // Steady pairs carry junk in_seg and in_base
      repeat (pairs) begin
         issue_uop(uop_pkg::op_cmps_src, agen_pkg::seg_id_t'(next_rand()), size,
                   next_rand(), 32'd0, 32'd0, r[12], 1'b1, 32'd0);
         issue_uop(uop_pkg::op_cmps_dst, agen_pkg::seg_id_t'(next_rand()), size,
                   next_rand(), 32'd0, 32'd0, r[12], 1'b1, 32'd0);
      end
   endtask

   // Compare process, samples away from the driving edge
   initial begin
      expect_t e;
      forever begin
         @(negedge clk);
         if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               fail_run("out_valid went high with no micro-op outstanding");
            end else begin
               e = exp_q.pop_front();
               check_tag(out_tag, e.tag);
               check_addr("out_addr", out_addr, e.addr);
               check_addr("out_offset", out_offset, e.offset);
               check_size(out_size, e.size);
               check_flag(out_limit_exc, e.exc, e.tag);
            end
         end
      end
   end

   initial begin
      logic [31:0] r;
      int          waited;
      rand_state = 32'h790e_3a22;
      tag_cnt = '0;
      ref_src_ptr = '0;
      ref_dst_ptr = '0;
      ref_src_seg = '0;
      ref_dst_seg = '0;
      rst = 1'b1;
      cfg_we = 1'b0;
      cfg_seg = '0;
      cfg_base = '0;
      cfg_limit = '0;
      in_valid = 1'b0;
      in_op = uop_pkg::op_mem;
      in_seg = '0;
      in_size = uop_pkg::size_1;
      in_base = '0;
      in_disp = '0;
      in_esp = '0;
      in_df = 1'b0;
      in_rep_steady = 1'b0;
      in_intr_addr = '0;
      in_tag = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      for (int i = 0; i < num_segs; i++)
         write_seg(agen_pkg::seg_id_t'(i), next_rand(), 32'h8000 + (next_rand() & 32'h1ffff));
      idle_cycle();

      repeat (80) begin
         r = next_rand();
         if (r[2:0] == 3'd0)
            idle_cycle();
         else
            random_uop();
      end
      limit_boundary(uop_pkg::op_mem, 3'd3);
      limit_boundary(uop_pkg::op_stack, 3'd6);
      limit_boundary(uop_pkg::op_intr, 3'd1);

      // Segment rewrites between micro-ops, including a limit at the 4G edge
      write_seg(3'd5, 32'h1000_0000, 32'hffff_ffff);
      issue_uop(uop_pkg::op_mem, 3'd5, uop_pkg::size_4, 32'hffff_fffe, 32'd0, 32'd0,
                1'b0, 1'b0, 32'd0);
      issue_uop(uop_pkg::op_mem, 3'd5, uop_pkg::size_1, 32'hffff_fff0, 32'hf, 32'd0,
                1'b0, 1'b0, 32'd0);
      write_seg(agen_pkg::seg_id_t'(stack_seg), 32'h0040_0000, 32'h0000_0100);
      limit_boundary(uop_pkg::op_stack, 3'd0);

      repeat (6) begin
         string_sequence(5);
         r = next_rand();
         if (r[0])
            idle_cycle();
      end
      idle_cycle();

      waited = 0;
      while (exp_q.size() != 0 && waited < drain_timeout) begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         fail_run("Timed out waiting for the outputs of the issued micro-ops");
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

// ==== project.f ====
source/agen_pkg.sv
source/uop_pkg.sv
source/seg_regs.sv
source/seg_limit_check.sv
source/string_addr_track.sv
source/agen_stage.sv
source/agen_top.sv
dv/agen_assert.sv
dv/agen_tb.sv

// ==== source/agen_pkg.sv ====
package agen_pkg;

   // Field widths
   localparam int addr_w   = 32;
   localparam int seg_id_w = 3;
   localparam int tag_w    = 8;

   // Address, offset or segment base and limit
   typedef logic [addr_w-1:0] addr_t;

   // Segment register number
   typedef logic [seg_id_w-1:0] seg_id_t;

   // Micro-op tag carried to the memory stage
   typedef logic [tag_w-1:0] tag_t;

endpackage

// ==== source/agen_stage.sv ====
module agen_stage #(
   parameter int STACK_SEG = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               in_valid,
   input  uop_pkg::op_t       in_op,
   input  agen_pkg::seg_id_t  in_seg,
   input  uop_pkg::mem_size_t in_size,
   input  agen_pkg::addr_t    in_base,
   input  agen_pkg::addr_t    in_disp,
   input  agen_pkg::addr_t    in_esp,
   input  logic               in_df,
   input  logic               in_rep_steady,
   input  agen_pkg::addr_t    in_intr_addr,
   input  agen_pkg::tag_t     in_tag,
   output agen_pkg::seg_id_t  seg_sel,
   input  agen_pkg::addr_t    seg_base,
   input  agen_pkg::addr_t    seg_limit,
   output logic               out_valid,
   output agen_pkg::addr_t    out_addr,
   output agen_pkg::addr_t    out_offset,
   output uop_pkg::mem_size_t out_size,
   output agen_pkg::tag_t     out_tag,
   output logic               out_limit_exc
);

   agen_pkg::addr_t   cmps_offset;
   agen_pkg::seg_id_t cmps_seg;
   agen_pkg::addr_t   offset;
   agen_pkg::addr_t   lin_addr;
   logic              is_intr;
   logic              limit_exc;

   assign is_intr = in_op == uop_pkg::op_intr;

   string_addr_track u_string_track (
      .clk        (clk),
      .rst        (rst),
      .valid      (in_valid),
      .op         (in_op),
      .size       (in_size),
      .df         (in_df),
      .rep_steady (in_rep_steady),
      .seg        (in_seg),
      .start      (in_base),
      .offset     (cmps_offset),
      .seg_out    (cmps_seg)
   );

   // Segment and offset by micro-op kind
   always_comb begin
      seg_sel = in_seg;
      offset  = in_base + in_disp;
      case (in_op)
         uop_pkg::op_stack: begin
            seg_sel = agen_pkg::seg_id_t'(STACK_SEG);
            offset  = in_esp;
         end
         uop_pkg::op_intr: offset = in_intr_addr;
         uop_pkg::op_cmps_src, uop_pkg::op_cmps_dst: begin
            seg_sel = cmps_seg;
            offset  = cmps_offset;
         end
         default: ;
      endcase
   end

   // Interrupt vectors bypass segmentation
   assign lin_addr = is_intr ? offset : seg_base + offset;

   seg_limit_check u_limit_check (
      .offset    (offset),
      .size      (in_size),
      .limit     (seg_limit),
      .check_en  (!is_intr),
      .limit_exc (limit_exc)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid     <= 1'b0;
         out_limit_exc <= 1'b0;
      end else begin
         out_valid     <= in_valid;
         out_limit_exc <= in_valid && limit_exc;
      end
   end

   always_ff @(posedge clk) begin
      out_addr   <= lin_addr;
      out_offset <= offset;
      out_size   <= in_size;
      out_tag    <= in_tag;
   end

endmodule

// ==== source/agen_top.sv ====
module agen_top #(
   parameter int STACK_SEG = 2,
   parameter int NUM_SEGS  = 8
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               cfg_we,
   input  agen_pkg::seg_id_t  cfg_seg,
   input  agen_pkg::addr_t    cfg_base,
   input  agen_pkg::addr_t    cfg_limit,
   input  logic               in_valid,
   input  uop_pkg::op_t       in_op,
   input  agen_pkg::seg_id_t  in_seg,
   input  uop_pkg::mem_size_t in_size,
   input  agen_pkg::addr_t    in_base,
   input  agen_pkg::addr_t    in_disp,
   input  agen_pkg::addr_t    in_esp,
   input  logic               in_df,
   input  logic               in_rep_steady,
   input  agen_pkg::addr_t    in_intr_addr,
   input  agen_pkg::tag_t     in_tag,
   output logic               out_valid,
   output agen_pkg::addr_t    out_addr,
   output agen_pkg::addr_t    out_offset,
   output uop_pkg::mem_size_t out_size,
   output agen_pkg::tag_t     out_tag,
   output logic               out_limit_exc
);

   agen_pkg::seg_id_t seg_sel;
   agen_pkg::addr_t   seg_base;
   agen_pkg::addr_t   seg_limit;

   seg_regs #(
      .NUM_SEGS (NUM_SEGS)
   ) u_seg_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_seg   (cfg_seg),
      .cfg_base  (cfg_base),
      .cfg_limit (cfg_limit),
      .rd_seg    (seg_sel),
      .rd_base   (seg_base),
      .rd_limit  (seg_limit)
   );

   agen_stage #(
      .STACK_SEG (STACK_SEG)
   ) u_agen_stage (
      .clk           (clk),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_op         (in_op),
      .in_seg        (in_seg),
      .in_size       (in_size),
      .in_base       (in_base),
      .in_disp       (in_disp),
      .in_esp        (in_esp),
      .in_df         (in_df),
      .in_rep_steady (in_rep_steady),
      .in_intr_addr  (in_intr_addr),
      .in_tag        (in_tag),
      .seg_sel       (seg_sel),
      .seg_base      (seg_base),
      .seg_limit     (seg_limit),
      .out_valid     (out_valid),
      .out_addr      (out_addr),
      .out_offset    (out_offset),
      .out_size      (out_size),
      .out_tag       (out_tag),
      .out_limit_exc (out_limit_exc)
   );

endmodule

// ==== source/seg_limit_check.sv ====
module seg_limit_check (
   input  agen_pkg::addr_t   offset,
   input  uop_pkg::mem_size_t size,
   input  agen_pkg::addr_t   limit,
   input  logic              check_en,
   output logic              limit_exc
);

   // Byte index of the last byte within the access
   logic [1:0] last_idx;

   // One extra bit so a wrap past 4G still counts as a violation
   logic [agen_pkg::addr_w:0] last_byte;
   logic [agen_pkg::addr_w:0] limit_ext;

   always_comb begin
      case (size)
         uop_pkg::size_1: last_idx = 2'd0;
         uop_pkg::size_2: last_idx = 2'd1;
         default:         last_idx = 2'd3;
      endcase
   end

   assign last_byte = {1'b0, offset} + {31'b0, last_idx};
   assign limit_ext = {1'b0, limit};

   assign limit_exc = check_en && (last_byte > limit_ext);

endmodule

// ==== source/seg_regs.sv ====
module seg_regs #(
   parameter int NUM_SEGS = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              cfg_we,
   input  agen_pkg::seg_id_t cfg_seg,
   input  agen_pkg::addr_t   cfg_base,
   input  agen_pkg::addr_t   cfg_limit,
   input  agen_pkg::seg_id_t rd_seg,
   output agen_pkg::addr_t   rd_base,
   output agen_pkg::addr_t   rd_limit
);

   agen_pkg::addr_t base_q  [NUM_SEGS];
   agen_pkg::addr_t limit_q [NUM_SEGS];

   logic rd_hit;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_SEGS; i++) begin
            base_q[i]  <= '0;
            limit_q[i] <= '0;
         end
      end else if (cfg_we && (int'(cfg_seg) < NUM_SEGS)) begin
         base_q[cfg_seg]  <= cfg_base;
         limit_q[cfg_seg] <= cfg_limit;
      end
   end

   // Segments past NUM_SEGS read as base 0, limit 0
   assign rd_hit = int'(rd_seg) < NUM_SEGS;

   always_comb begin
      rd_base  = '0;
      rd_limit = '0;
      if (rd_hit) begin
         rd_base  = base_q[rd_seg];
         rd_limit = limit_q[rd_seg];
      end
   end

endmodule

// ==== source/string_addr_track.sv ====
module string_addr_track (
   input  logic               clk,
   input  logic               rst,
   input  logic               valid,
   input  uop_pkg::op_t       op,
   input  uop_pkg::mem_size_t size,
   input  logic               df,
   input  logic               rep_steady,
   input  agen_pkg::seg_id_t  seg,
   input  agen_pkg::addr_t    start,
   output agen_pkg::addr_t    offset,
   output agen_pkg::seg_id_t  seg_out
);

   // Saved index pointers, src for the first uop and dst for the second
   agen_pkg::addr_t   src_ptr_q;
   agen_pkg::addr_t   dst_ptr_q;
   agen_pkg::seg_id_t src_seg_q;
   agen_pkg::seg_id_t dst_seg_q;

   agen_pkg::addr_t   step_mag;
   agen_pkg::addr_t   step;
   agen_pkg::addr_t   saved_ptr;
   agen_pkg::seg_id_t saved_seg;
   agen_pkg::addr_t   base;
   logic              is_src;
   logic              is_dst;

   assign is_src = op == uop_pkg::op_cmps_src;
   assign is_dst = op == uop_pkg::op_cmps_dst;

   always_comb begin
      case (size)
         uop_pkg::size_1: step_mag = 32'd1;
         uop_pkg::size_2: step_mag = 32'd2;
         default:         step_mag = 32'd4;
      endcase
   end

   // DF set walks the strings downwards
   assign step = df ? ('0 - step_mag) : step_mag;

   assign saved_ptr = is_dst ? dst_ptr_q : src_ptr_q;
   assign saved_seg = is_dst ? dst_seg_q : src_seg_q;

   assign base    = rep_steady ? saved_ptr : start;
   assign offset  = base + step;
   assign seg_out = rep_steady ? saved_seg : seg;

   always_ff @(posedge clk) begin
      if (rst) begin
         src_ptr_q <= '0;
         dst_ptr_q <= '0;
         src_seg_q <= '0;
         dst_seg_q <= '0;
      end else if (valid) begin
         if (is_src) begin
            src_ptr_q <= offset;
            src_seg_q <= seg_out;
         end
         if (is_dst) begin
            dst_ptr_q <= offset;
            dst_seg_q <= seg_out;
         end
      end
   end

endmodule

// ==== source/uop_pkg.sv ====
package uop_pkg;

   // Micro-op kind
   typedef logic [2:0] op_t;

   localparam op_t op_mem      = 3'd0;
   localparam op_t op_stack    = 3'd1;
   localparam op_t op_intr     = 3'd2;
   localparam op_t op_cmps_src = 3'd3;
   localparam op_t op_cmps_dst = 3'd4;

   // Access size, code 3 is reserved and counts as 4 bytes
   typedef logic [1:0] mem_size_t;

   localparam mem_size_t size_1 = 2'd0;
   localparam mem_size_t size_2 = 2'd1;
   localparam mem_size_t size_4 = 2'd2;

endpackage
